//--- hdl/aesFeeder.sv
// AES input stage
`default_nettype none

module aesFeeder (
  input  wire                           CLK,
  input  wire                           RST,
  input  wire                           keyValid,
  input  wire [aesPkg::blockWidth-1:0]  key,
  input  wire                           inValid,
  output logic                          inReady,
  input  wire [aesPkg::blockWidth-1:0]  inData,
  roundIf.source                        down
);

  logic [aesPkg::blockWidth-1:0] keyReg;
  logic [aesPkg::blockWidth-1:0] roundKeyReg;
  aesPkg::aesState stateReg;
  logic validReg;

  assign inReady = !validReg || down.ready;

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      validReg <= 1'b0;
    end else if (inReady) begin
      validReg <= inValid;
    end
  end

  // a block taken on the load edge still sees the old key
  always_ff @(posedge CLK) begin
    if (keyValid) begin
      keyReg <= key;
    end
  end

  // initial AddRoundKey
  always_ff @(posedge CLK) begin
    if (inValid && inReady) begin
      stateReg.word <= inData ^ keyReg;
      roundKeyReg <= keyReg;
    end
  end

  assign down.valid = validReg;
  assign down.state = stateReg;
  assign down.roundKey = roundKeyReg;

endmodule

`default_nettype wire

//--- hdl/aesFinalRound.sv
// AES final round and output
`default_nettype none

module aesFinalRound (
  input  wire                           CLK,
  input  wire                           RST,
  roundIf.sink                          up,
  output logic                          outValid,
  input  wire                           outReady,
  output logic [aesPkg::blockWidth-1:0] outData
);

  logic [aesPkg::blockWidth-1:0] lastKey;
  aesPkg::aesState shifted;

  // round 10 skips MixColumns
  always_comb begin
    lastKey = aesPkg::nextRoundKey(up.roundKey, aesPkg::roundConst(aesPkg::numRounds - 1));
    shifted = aesPkg::shiftRows(aesPkg::subBytes(up.state));
  end

  assign up.ready = !outValid || outReady;

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      outValid <= 1'b0;
    end else if (up.ready) begin
      outValid <= up.valid;
    end
  end

  // ciphertext holds while the consumer stalls
  always_ff @(posedge CLK) begin
    if (up.valid && up.ready) begin
      outData <= shifted.word ^ lastKey;
    end
  end

endmodule

`default_nettype wire

//--- hdl/aesPipeline.sv
// AES-128 pipelined encryptor
`default_nettype none

module aesPipeline (
  input  wire                           CLK,
  input  wire                           RST,
  input  wire                           keyValid,
  input  wire [aesPkg::blockWidth-1:0]  key,
  input  wire                           inValid,
  output logic                          inReady,
  input  wire [aesPkg::blockWidth-1:0]  inData,
  output logic                          outValid,
  input  wire                           outReady,
  output logic [aesPkg::blockWidth-1:0] outData
);

  // link[i] feeds round i+1, the last one feeds the final round
  roundIf link [0:aesPkg::numRounds-1] ();

  aesFeeder i_feeder (
    .CLK      (CLK),
    .RST      (RST),
    .keyValid (keyValid),
    .key      (key),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .down     (link[0])
  );

  for (genvar g = 0; g < aesPkg::numRounds - 1; g++) begin : genRound
    aesRound #(
      .rcon (aesPkg::roundConst(g))
    ) i_round (
      .CLK  (CLK),
      .RST  (RST),
      .up   (link[g]),
      .down (link[g+1])
    );
  end

  aesFinalRound i_finalRound (
    .CLK      (CLK),
    .RST      (RST),
    .up       (link[aesPkg::numRounds-1]),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

endmodule

`default_nettype wire

//--- hdl/aesPkg.sv
// AES-128 definitions
`default_nettype none

package aesPkg;

  localparam int blockWidth = 128;
  localparam int numRounds = 10;
  localparam logic [7:0] rconFirst = 8'h01;

  // column 0 sits in the top word, row 0 in the top byte of each column
  typedef union packed {
    logic [blockWidth-1:0] word;
    logic [3:0][3:0][7:0] col;
  } aesState;

  // multiply by 2 in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // round constant for a zero-based round index
  function automatic logic [7:0] roundConst(input int idx);
    logic [7:0] rc;
    rc = rconFirst;
    for (int i = 0; i < idx; i++) begin
      rc = xtime(rc);
    end
    return rc;
  endfunction

  function automatic logic [7:0] sbox(input logic [7:0] b);
    logic [0:255][7:0] lut;
    lut = {128'h637c777bf26b6fc53001672bfed7ab76,
           128'hca82c97dfa5947f0add4a2af9ca472c0,
           128'hb7fd9326363ff7cc34a5e5f171d83115,
           128'h04c723c31896059a071280e2eb27b275,
           128'h09832c1a1b6e5aa0523bd6b329e32f84,
           128'h53d100ed20fcb15b6acbbe394a4c58cf,
           128'hd0efaafb434d338545f9027f503c9fa8,
           128'h51a3408f929d38f5bcb6da2110fff3d2,
           128'hcd0c13ec5f974417c4a77e3d645d1973,
           128'h60814fdc222a908846eeb814de5e0bdb,
           128'he0323a0a4906245cc2d3ac629195e479,
           128'he7c8376d8dd54ea96c56f4ea657aae08,
           128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
           128'h703eb5664803f60e613557b986c11d9e,
           128'he1f8981169d98e949b1e87e9ce5528df,
           128'h8ca1890dbfe6426841992d0fb054bb16};
    return lut[b];
  endfunction

  function automatic logic [31:0] subWord(input logic [31:0] w);
    return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
  endfunction

  function automatic aesState subBytes(input aesState s);
    aesState o;
    for (int c = 0; c < 4; c++) begin
      o.col[c] = subWord(s.col[c]);
    end
    return o;
  endfunction

  // row r rotates left by r columns
  function automatic aesState shiftRows(input aesState s);
    aesState o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o.col[3-c][3-r] = s.col[3-((c+r)%4)][3-r];
      end
    end
    return o;
  endfunction

  // 2a ^ 3b ^ c ^ d per byte, written as t ^ a ^ xtime(a ^ b)
  function automatic logic [31:0] mixColumn(input logic [31:0] c);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    logic [7:0] t;
    a0 = c[31:24];
    a1 = c[23:16];
    a2 = c[15:8];
    a3 = c[7:0];
    t = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ t ^ xtime(a0 ^ a1),
            a1 ^ t ^ xtime(a1 ^ a2),
            a2 ^ t ^ xtime(a2 ^ a3),
            a3 ^ t ^ xtime(a3 ^ a0)};
  endfunction

  function automatic logic [blockWidth-1:0] nextRoundKey(
    input logic [blockWidth-1:0] k,
    input logic [7:0] rc
  );
    logic [31:0] temp;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    temp = subWord({k[23:0], k[31:24]}) ^ {rc, 24'h000000};
    w0 = k[127:96] ^ temp;
    w1 = k[95:64] ^ w0;
    w2 = k[63:32] ^ w1;
    w3 = k[31:0] ^ w2;
    return {w0, w1, w2, w3};
  endfunction

endpackage

`default_nettype wire

//--- hdl/aesRound.sv
// AES full round stage
`default_nettype none

module aesRound #(
  parameter logic [7:0] rcon = aesPkg::rconFirst
) (
  input  wire    CLK,
  input  wire    RST,
  roundIf.sink   up,
  roundIf.source down
);

  logic [aesPkg::blockWidth-1:0] nextKey;
  logic [aesPkg::blockWidth-1:0] keyReg;
  aesPkg::aesState shifted;
  aesPkg::aesState mixed;
  aesPkg::aesState stateReg;
  logic validReg;

  // key schedule step runs alongside the data path
  always_comb begin
    nextKey = aesPkg::nextRoundKey(up.roundKey, rcon);
    shifted = aesPkg::shiftRows(aesPkg::subBytes(up.state));
    for (int c = 0; c < 4; c++) begin
      mixed.col[c] = aesPkg::mixColumn(shifted.col[c]);
    end
  end

  // slot frees up when empty or drained this cycle
  assign up.ready = !validReg || down.ready;

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      validReg <= 1'b0;
    end else if (up.ready) begin
      validReg <= up.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (up.valid && up.ready) begin
      stateReg.word <= mixed.word ^ nextKey;
      keyReg <= nextKey;
    end
  end

  assign down.valid = validReg;
  assign down.state = stateReg;
  assign down.roundKey = keyReg;

endmodule

`default_nettype wire

//--- hdl/roundIf.sv
// Pipeline stage link
`default_nettype none

interface roundIf;

  logic valid;
  logic ready;
  aesPkg::aesState state;
  logic [aesPkg::blockWidth-1:0] roundKey;

  modport source (output valid, output state, output roundKey, input ready);

  modport sink (input valid, input state, input roundKey, output ready);

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the AES pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tbAes -o simAes
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/simAes +verilator+error+limit+1000 > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "testbench reported failures, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0

//--- tests/aesChecker.sv
// Output scoreboard
`default_nettype none

module aesChecker (
  input wire                          CLK,
  input wire                          RST,
  input wire                          inValid,
  input wire                          inReady,
  input wire                          outValid,
  input wire                          outReady,
  input wire [aesPkg::blockWidth-1:0] outData
);

  logic [aesPkg::blockWidth-1:0] expQ [$];
  int mismatchCount = 0;
  int otherCount = 0;
  int cycle = 0;
  int acceptCycle = -1;
  logic seenOut = 1'b0;

  task automatic pushExpected(input logic [aesPkg::blockWidth-1:0] value);
    expQ.push_back(value);
  endtask

  function automatic int pendingCount();
    return expQ.size();
  endfunction

  task automatic checkDrained();
    if (expQ.size() != 0) begin
      $display("%0d expected blocks never came out of the pipeline", expQ.size());
      otherCount++;
    end
  endtask

  // values seen here are the ones before the edge
  always @(posedge CLK) begin : watch
    logic [aesPkg::blockWidth-1:0] want;
    cycle++;
    if (RST && inValid && inReady && acceptCycle < 0) begin
      acceptCycle = cycle;
    end
    if (RST && outValid && !seenOut) begin
      seenOut = 1'b1;
      if (cycle - acceptCycle != 11) begin
        $display("at %0t the first block took %0d edges instead of 11",
                 $time, cycle - acceptCycle);
        otherCount++;
      end
    end
    if (RST && outValid && outReady) begin
      if (expQ.size() == 0) begin
        $display("at %0t an output block arrived with no expected value", $time);
        otherCount++;
      end else begin
        want = expQ.pop_front();
        if (outData !== want) begin
          $display("[FAIL] %0t outData expected %h actual %h", $time, want, outData);
          mismatchCount++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/aesInput.txt
// key, plaintext, expected ciphertext (128-bit hex words)
// FIPS-197 vectors in mixed order with repeats
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a

//--- tests/aesPipeline_sva.sv
// Output handshake assertions
`default_nettype none

module aesPipelineSva (
  input wire                          CLK,
  input wire                          RST,
  input wire                          inReady,
  input wire                          outValid,
  input wire                          outReady,
  input wire [aesPkg::blockWidth-1:0] outData
);

  int failCount = 0;

  // a stalled output keeps its word
  holdOnStall: assert property (@(posedge CLK) disable iff (!RST)
    outValid && !outReady |=> outValid && $stable(outData))
    else begin
      failCount++;
      $error("output changed while the consumer stalled");
    end

  idleAfterReset: assert property (@(posedge CLK) $rose(RST) |-> !outValid)
    else begin
      failCount++;
      $error("outValid high right after reset");
    end

  readyAfterReset: assert property (@(posedge CLK) $rose(RST) |-> inReady)
    else begin
      failCount++;
      $error("inReady low right after reset");
    end

endmodule

`default_nettype wire

//--- tests/tbAes.sv
// AES pipeline testbench
`default_nettype none

module tbAes;

  localparam int numRecords = 12;
  localparam int cycleLimit = 40 * numRecords + 100;

  logic CLK;
  logic RST;
  logic keyValid;
  logic [aesPkg::blockWidth-1:0] key;
  logic inValid;
  logic inReady;
  logic [aesPkg::blockWidth-1:0] inData;
  logic outValid;
  logic outReady;
  logic [aesPkg::blockWidth-1:0] outData;

  // three words per record: key, plaintext, expected ciphertext
  logic [aesPkg::blockWidth-1:0] vectors [0:3*numRecords-1];
  logic [aesPkg::blockWidth-1:0] lastKey;
  logic keyLoaded;
  logic stallMode;
  logic accepted;
  integer seed;
  int cycleCount;
  int totalErrors;

  aesPipeline i_aesPipeline (
    .CLK      (CLK),
    .RST      (RST),
    .keyValid (keyValid),
    .key      (key),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  aesChecker i_checker (
    .CLK      (CLK),
    .RST      (RST),
    .inValid  (inValid),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  bind aesPipeline aesPipelineSva i_sva (
    .CLK      (CLK),
    .RST      (RST),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // consumer back-pressure, random only in the stall phase
  always @(negedge CLK) begin
    if (stallMode) begin
      outReady = ($random(seed) & 3) != 0;
    end else begin
      outReady = 1'b1;
    end
  end

  // input handshake as seen on the edge
  always @(posedge CLK) begin
    accepted <= inValid && inReady;
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles, pipeline did not drain", cycleCount);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // loads the record's key first when it differs from the current one
  task automatic sendRecord(input int idx, input int gap);
    logic [aesPkg::blockWidth-1:0] recKey;
    recKey = vectors[3*idx];
    repeat (gap) @(negedge CLK);
    if (!keyLoaded || recKey != lastKey) begin
      key = recKey;
      keyValid = 1'b1;
      @(negedge CLK);
      keyValid = 1'b0;
      lastKey = recKey;
      keyLoaded = 1'b1;
    end
    i_checker.pushExpected(vectors[3*idx+2]);
    inData = vectors[3*idx+1];
    inValid = 1'b1;
    @(negedge CLK);
    while (!accepted) @(negedge CLK);
    inValid = 1'b0;
  endtask

  initial begin
    seed = 32'he46ba7ea;
    RST = 1'b0;
    keyValid = 1'b0;
    key = '0;
    inValid = 1'b0;
    inData = '0;
    outReady = 1'b1;
    stallMode = 1'b0;
    keyLoaded = 1'b0;
    accepted = 1'b0;
    lastKey = '0;
    cycleCount = 0;
    $readmemh("tests/aesInput.txt", vectors);
    repeat (2) @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    // lone block, latency is measured on it
    sendRecord(0, 0);
    while (i_checker.pendingCount() != 0) @(negedge CLK);
    for (int i = 1; i < 5; i++) begin
      sendRecord(i, 0);
    end
    stallMode = 1'b1;
    for (int i = 5; i < numRecords; i++) begin
      sendRecord(i, $random(seed) & 3);
    end
    while (i_checker.pendingCount() != 0) @(negedge CLK);
    stallMode = 1'b0;
    repeat (4) @(negedge CLK);
    i_checker.checkDrained();
    totalErrors = i_checker.mismatchCount + i_checker.otherCount
                + i_aesPipeline.i_sva.failCount;
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             i_checker.mismatchCount, i_checker.otherCount, i_aesPipeline.i_sva.failCount);
    if (totalErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hdl/aesPkg.sv
hdl/roundIf.sv
hdl/aesFeeder.sv
hdl/aesRound.sv
hdl/aesFinalRound.sv
hdl/aesPipeline.sv
tests/aesPipeline_sva.sv
tests/aesChecker.sv
tests/tbAes.sv
